//--- sim.f
cart_cmd_pkg.sv
spi_byte_port.sv
mcu_cmd.sv
sd_dma.sv
store_arbiter.sv
byte_store.sv
cart_cmd_top.sv
tb_cart_cmd.sv

//--- tb_cart_cmd.sv
`timescale 1ns/100ps

module tb_cart_cmd import cart_cmd_pkg::*; ();

  localparam int buf_len = 80;
  // about 300 spi bytes at roughly 130 clk each plus sd gaps, so this is generous
  localparam int max_cycles = 200000;

  logic                  clk;
  logic                  reset;
  logic                  sck;
  logic                  cs_n;
  logic                  mosi;
  logic                  miso;
  logic                  sd_valid;
  logic                  sd_ready;
  logic [7:0]            sd_data;
  logic [3:0]            mapper;
  logic [rom_mask_w-1:0] rom_mask;

  // frame buffers and the expected store contents
  logic [7:0] tx_buf [buf_len];
  logic [7:0] rx_buf [buf_len];
  logic [7:0] exp_mem [store_depth];

  int seed;
  int errors;
  int test_err_start;
  int tests_passed;
  int tests_failed;
  int cycle_cnt;

  cart_cmd_top cart_cmd_top_i (
    .clk(clk), .reset(reset),
    .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .sd_valid(sd_valid), .sd_ready(sd_ready), .sd_data(sd_data),
    .mapper(mapper), .rom_mask(rom_mask)
  );

  always #20 clk = ~clk;

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still going after %0d clock cycles", max_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_mapper(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input logic [rom_mask_w-1:0] got,
                            input logic [rom_mask_w-1:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %06h expected %06h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_err_start) begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d mismatches", num, name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // bus drivers

  // mode 0, msb first, 16 clk per bit
  task automatic spi_frame(input int n);
    int i;
    int b;
    @(negedge clk);
    cs_n = 1'b0;
    repeat (8) @(negedge clk);
    for (i = 0; i < n; i++) begin
      for (b = 7; b >= 0; b--) begin
        mosi = tx_buf[i][b];
        repeat (8) @(negedge clk);
        // miso is sampled as sck rises
        rx_buf[i][b] = miso;
        sck = 1'b1;
        repeat (8) @(negedge clk);
        sck = 1'b0;
      end
    end
    repeat (8) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (8) @(negedge clk);
    check_byte(rx_buf[0], 8'h00, "reply byte 0");
  endtask

  task automatic sd_send(input int base, input int n);
    int i;
    int gap;
    for (i = 0; i < n; i++) begin
      gap = $unsigned($random(seed)) % 64;
      repeat (gap) @(negedge clk);
      sd_valid = 1'b1;
      sd_data  = exp_mem[base + i];
      // byte held until the engine takes it
      while (!sd_ready)
        @(negedge clk);
      @(negedge clk);
      sd_valid = 1'b0;
    end
  endtask

  task automatic fill_random(input int base, input int n);
    int i;
    for (i = 0; i < n; i++)
      exp_mem[base + i] = $random(seed);
  endtask

  task automatic set_addr(input int addr);
    tx_buf[0] = op_set_addr;
    tx_buf[1] = addr[15:8];
    tx_buf[2] = addr[7:0];
    spi_frame(3);
  endtask

  task automatic write_bytes(input int base, input int n);
    int i;
    set_addr(base);
    tx_buf[0] = op_write;
    for (i = 0; i < n; i++)
      tx_buf[i + 1] = exp_mem[base + i];
    spi_frame(n + 1);
  endtask

  // reply byte k carries the byte at base + k - 1
  task automatic read_check(input int base, input int n, input string what);
    int i;
    set_addr(base);
    tx_buf[0] = op_read;
    for (i = 0; i < n; i++)
      tx_buf[i + 1] = 8'h00;
    spi_frame(n + 1);
    for (i = 0; i < n; i++)
      check_byte(rx_buf[i + 1], exp_mem[base + i], $sformatf("%s at %03h", what, base + i));
  endtask

  task automatic dma_start_cmd(input int n);
    tx_buf[0] = op_dma_start;
    tx_buf[1] = n[7:0];
    spi_frame(2);
  endtask

  task automatic wait_dma_idle();
    int  polls;
    logic busy;
    polls = 0;
    busy  = 1'b1;
    while (busy && polls < 40) begin
      tx_buf[0] = op_status;
      tx_buf[1] = 8'h00;
      spi_frame(2);
      busy = rx_buf[1][7];
      check_byte(rx_buf[1] & 8'h7F, 8'h00, "status spare bits");
      polls++;
    end
    if (busy) begin
      errors++;
      $display("DMA was still busy after %0d status polls", polls);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic test_mapper_mask();
    check_mapper(mapper, 4'd1, "mapper after reset");
    check_mask(rom_mask, '0, "rom mask after reset");
    check_flag(sd_ready, 1'b0, "sd_ready after reset");
    tx_buf[0] = 8'h31;
    spi_frame(1);
    check_mapper(mapper, 4'd1, "mapper after 0x31");
    tx_buf[0] = 8'h3C;
    spi_frame(1);
    check_mapper(mapper, 4'd12, "mapper after 0x3c");
    tx_buf[0] = op_rom_mask;
    tx_buf[1] = 8'h12;
    tx_buf[2] = 8'h34;
    tx_buf[3] = 8'h56;
    spi_frame(4);
    check_mask(rom_mask, 24'h123456, "rom mask");
    end_test(1, "mapper and rom mask");
  endtask

  task automatic test_signature();
    tx_buf[0] = op_signature;
    tx_buf[1] = 8'h00;
    spi_frame(2);
    check_byte(rx_buf[1], 8'hA5, "signature reply");
    end_test(2, "signature");
  endtask

  task automatic test_burst();
    fill_random(16'h0040, 16);
    write_bytes(16'h0040, 16);
    read_check(16'h0040, 16, "burst read");
    end_test(3, "write and read burst");
  endtask

  task automatic test_dma();
    fill_random(16'h0100, 40);
    set_addr(16'h0100);
    dma_start_cmd(40);
    tx_buf[0] = op_status;
    tx_buf[1] = 8'h00;
    spi_frame(2);
    check_byte(rx_buf[1], 8'h80, "status while dma waits");
    check_flag(sd_ready, 1'b1, "sd_ready while dma waits");
    sd_send(16'h0100, 40);
    wait_dma_idle();
    check_flag(sd_ready, 1'b0, "sd_ready after dma");
    read_check(16'h0100, 40, "dma data");
    end_test(4, "sd dma");
  endtask

  // dma into 0x200 while spi writes 0x300, borders at 0x1ff and 0x23c
  task automatic test_dma_with_spi();
    fill_random(16'h01FF, 62);
    write_bytes(16'h01FF, 62);
    fill_random(16'h0200, 60);
    fill_random(16'h0300, 20);
    set_addr(16'h0200);
    dma_start_cmd(60);
    fork
      sd_send(16'h0200, 60);
      write_bytes(16'h0300, 20);
    join
    wait_dma_idle();
    read_check(16'h01FF, 62, "dma region and borders");
    read_check(16'h0300, 20, "spi region");
    end_test(5, "dma with spi traffic");
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    sck            = 1'b0;
    cs_n           = 1'b1;
    mosi           = 1'b0;
    sd_valid       = 1'b0;
    sd_data        = 8'h00;
    seed           = 16545;
    errors         = 0;
    test_err_start = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    test_mapper_mask();
    test_signature();
    test_burst();
    test_dma();
    test_dma_with_spi();

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- cart_cmd_top.sv
`timescale 1ns/100ps

module cart_cmd_top import cart_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  sck,
  input  logic                  cs_n,
  input  logic                  mosi,
  output logic                  miso,
  input  logic                  sd_valid,
  output logic                  sd_ready,
  input  logic [7:0]            sd_data,
  output logic [3:0]            mapper,
  output logic [rom_mask_w-1:0] rom_mask
);

  ////////////////////////////////////////////////////////////
  // spi to decoder

  logic [7:0] tx_data;
  logic [7:0] rx_data;
  logic [7:0] byte_cnt;
  logic       cmd_ready;
  logic       param_ready;
  logic       frame_end;

  // decoder to dma
  logic                    dma_start;
  logic [store_addr_w-1:0] dma_addr;
  logic [7:0]              dma_count;
  logic                    dma_busy;

  // requester side of the arbiter
  logic                    cmd_req_valid;
  logic                    cmd_req_ready;
  logic                    cmd_req_we;
  logic [store_addr_w-1:0] cmd_req_addr;
  logic [7:0]              cmd_req_wdata;
  logic                    cmd_rdata_valid;
  logic                    dma_req_valid;
  logic                    dma_req_ready;
  logic                    dma_req_we;
  logic [store_addr_w-1:0] dma_req_addr;
  logic [7:0]              dma_req_wdata;

  // store side
  logic                    mem_en;
  logic                    mem_we;
  logic [store_addr_w-1:0] mem_addr;
  logic [7:0]              mem_wdata;
  logic [7:0]              rdata;

  spi_byte_port spi_byte_port_i (
    .clk(clk), .reset(reset),
    .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .tx_data(tx_data),
    .cmd_ready(cmd_ready), .param_ready(param_ready),
    .rx_data(rx_data), .byte_cnt(byte_cnt), .frame_end(frame_end)
  );

  mcu_cmd mcu_cmd_i (
    .clk(clk), .reset(reset),
    .cmd_ready(cmd_ready), .param_ready(param_ready),
    .rx_data(rx_data), .byte_cnt(byte_cnt), .frame_end(frame_end),
    .tx_data(tx_data), .mapper(mapper), .rom_mask(rom_mask),
    .dma_start(dma_start), .dma_addr(dma_addr), .dma_count(dma_count),
    .dma_busy(dma_busy),
    .req_valid(cmd_req_valid), .req_ready(cmd_req_ready),
    .req_we(cmd_req_we), .req_addr(cmd_req_addr), .req_wdata(cmd_req_wdata),
    .rdata(rdata), .rdata_valid(cmd_rdata_valid)
  );

  sd_dma sd_dma_i (
    .clk(clk), .reset(reset),
    .dma_start(dma_start), .dma_addr(dma_addr), .dma_count(dma_count),
    .dma_busy(dma_busy),
    .sd_valid(sd_valid), .sd_ready(sd_ready), .sd_data(sd_data),
    .req_valid(dma_req_valid), .req_ready(dma_req_ready),
    .req_we(dma_req_we), .req_addr(dma_req_addr), .req_wdata(dma_req_wdata)
  );

  // dma only writes, so its read-valid stays open
  store_arbiter store_arbiter_i (
    .clk(clk), .reset(reset),
    .cmd_req_valid(cmd_req_valid), .cmd_req_ready(cmd_req_ready),
    .cmd_req_we(cmd_req_we), .cmd_req_addr(cmd_req_addr),
    .cmd_req_wdata(cmd_req_wdata), .cmd_rdata_valid(cmd_rdata_valid),
    .dma_req_valid(dma_req_valid), .dma_req_ready(dma_req_ready),
    .dma_req_we(dma_req_we), .dma_req_addr(dma_req_addr),
    .dma_req_wdata(dma_req_wdata), .dma_rdata_valid(),
    .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  byte_store byte_store_i (
    .clk(clk),
    .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .rdata(rdata)
  );

endmodule

//--- byte_store.sv
`timescale 1ns/100ps

module byte_store import cart_cmd_pkg::*; (
  input  logic                    clk,
  input  logic                    mem_en,
  input  logic                    mem_we,
  input  logic [store_addr_w-1:0] mem_addr,
  input  logic [7:0]              mem_wdata,
  output logic [7:0]              rdata
);

  logic [7:0] mem [store_depth];

  // single port, registered read
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_we)
        mem[mem_addr] <= mem_wdata;
      else
        rdata <= mem[mem_addr];
    end
  end

endmodule

//--- store_arbiter.sv
`timescale 1ns/100ps

module store_arbiter import cart_cmd_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_req_valid,
  output logic                    cmd_req_ready,
  input  logic                    cmd_req_we,
  input  logic [store_addr_w-1:0] cmd_req_addr,
  input  logic [7:0]              cmd_req_wdata,
  output logic                    cmd_rdata_valid,
  input  logic                    dma_req_valid,
  output logic                    dma_req_ready,
  input  logic                    dma_req_we,
  input  logic [store_addr_w-1:0] dma_req_addr,
  input  logic [7:0]              dma_req_wdata,
  output logic                    dma_rdata_valid,
  output logic                    mem_en,
  output logic                    mem_we,
  output logic [store_addr_w-1:0] mem_addr,
  output logic [7:0]              mem_wdata
);

  // set when the dma side won the last grant
  logic last_dma;
  logic grant_cmd;
  logic grant_dma;

  assign grant_cmd = cmd_req_valid & (~dma_req_valid | last_dma);
  assign grant_dma = dma_req_valid & (~cmd_req_valid | ~last_dma);

  assign cmd_req_ready = grant_cmd;
  assign dma_req_ready = grant_dma;

  assign mem_en    = grant_cmd | grant_dma;
  assign mem_we    = grant_cmd ? cmd_req_we    : dma_req_we;
  assign mem_addr  = grant_cmd ? cmd_req_addr  : dma_req_addr;
  assign mem_wdata = grant_cmd ? cmd_req_wdata : dma_req_wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_dma        <= 1'b0;
      cmd_rdata_valid <= 1'b0;
      dma_rdata_valid <= 1'b0;
    end else begin
      if (mem_en)
        last_dma <= grant_dma;
      // read data belongs to whoever issued the read
      cmd_rdata_valid <= grant_cmd & ~cmd_req_we;
      dma_rdata_valid <= grant_dma & ~dma_req_we;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(cmd_req_ready && dma_req_ready))
    else $error("store_arbiter: both requesters granted");

endmodule

//--- sd_dma.sv
`timescale 1ns/100ps

module sd_dma import cart_cmd_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    dma_start,
  input  logic [store_addr_w-1:0] dma_addr,
  input  logic [7:0]              dma_count,
  output logic                    dma_busy,
  input  logic                    sd_valid,
  output logic                    sd_ready,
  input  logic [7:0]              sd_data,
  output logic                    req_valid,
  input  logic                    req_ready,
  output logic                    req_we,
  output logic [store_addr_w-1:0] req_addr,
  output logic [7:0]              req_wdata
);

  logic [7:0] remaining;
  logic       start_ok;
  logic       sd_take;
  logic       wr_done;

  assign start_ok = dma_start & ~dma_busy;
  assign sd_take  = sd_valid & sd_ready;
  assign wr_done  = req_valid & req_ready;

  // one byte in flight at a time
  assign sd_ready = dma_busy & ~req_valid;
  // this engine only ever writes
  assign req_we   = 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      dma_busy  <= 1'b0;
      req_valid <= 1'b0;
      remaining <= '0;
    end else begin
      if (start_ok) begin
        dma_busy  <= (dma_count != 8'd0);
        remaining <= dma_count;
      end
      if (sd_take) begin
        req_valid <= 1'b1;
        remaining <= remaining - 8'd1;
      end
      if (wr_done) begin
        req_valid <= 1'b0;
        if (remaining == 8'd0)
          dma_busy <= 1'b0;
      end
    end
  end

  // write address runs from dma_addr
  always_ff @(posedge clk) begin
    if (start_ok)
      req_addr <= dma_addr;
    else if (wr_done)
      req_addr <= req_addr + 1'b1;
    if (sd_take)
      req_wdata <= sd_data;
  end

  assert property (@(posedge clk) disable iff (reset) dma_start |-> !dma_busy)
    else $error("sd_dma: start while busy ignored");

endmodule

//--- mcu_cmd.sv
`timescale 1ns/100ps

module mcu_cmd import cart_cmd_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_ready,
  input  logic                    param_ready,
  input  logic [7:0]              rx_data,
  input  logic [7:0]              byte_cnt,
  input  logic                    frame_end,
  output logic [7:0]              tx_data,
  output logic [3:0]              mapper,
  output logic [rom_mask_w-1:0]   rom_mask,
  output logic                    dma_start,
  output logic [store_addr_w-1:0] dma_addr,
  output logic [7:0]              dma_count,
  input  logic                    dma_busy,
  output logic                    req_valid,
  input  logic                    req_ready,
  output logic                    req_we,
  output logic [store_addr_w-1:0] req_addr,
  output logic [7:0]              req_wdata,
  input  logic [7:0]              rdata,
  input  logic                    rdata_valid
);

  logic [7:0]              cmd_reg;
  logic                    cmd_active;
  logic [store_addr_w-1:0] addr;
  logic [7:0]              cur_cmd;
  logic                    param_evt;
  logic                    byte_evt;
  logic                    wr_evt;
  logic                    rd_evt;
  logic                    dma_evt;

  // stray parameter bytes after frame end are ignored
  assign param_evt = param_ready & cmd_active;
  assign byte_evt  = cmd_ready | param_evt;
  assign cur_cmd   = cmd_ready ? rx_data : cmd_reg;

  assign wr_evt  = param_evt & (cmd_reg == op_write);
  assign rd_evt  = byte_evt & (cur_cmd == op_read);
  assign dma_evt = param_evt & (cmd_reg == op_dma_start) & (byte_cnt == 8'd1);

  ////////////////////////////////////////////////////////////
  // command and parameter decode

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_reg    <= '0;
      cmd_active <= 1'b0;
      mapper     <= 4'd1;
      rom_mask   <= '0;
      addr       <= '0;
      dma_start  <= 1'b0;
      req_valid  <= 1'b0;
      tx_data    <= '0;
    end else begin
      dma_start <= dma_evt;
      if (req_valid && req_ready)
        req_valid <= 1'b0;
      if (frame_end)
        cmd_active <= 1'b0;
      if (cmd_ready) begin
        cmd_reg    <= rx_data;
        cmd_active <= 1'b1;
        if (rx_data[7:4] == op_mapper)
          mapper <= rx_data[3:0];
      end
      if (param_evt) begin
        case (cmd_reg)
          op_set_addr:
            case (byte_cnt)
              8'd1: addr <= {rx_data[store_addr_w-9:0], 8'h00};
              8'd2: addr[7:0] <= rx_data;
              default: ;
            endcase
          op_rom_mask:
            if (byte_cnt >= 8'd1 && byte_cnt <= 8'd3)
              rom_mask <= {rom_mask[rom_mask_w-9:0], rx_data};
          default: ;
        endcase
      end
      // one store access per burst byte, address steps afterwards
      if (wr_evt || rd_evt) begin
        req_valid <= 1'b1;
        addr      <= addr + 1'b1;
      end
      // reply for the next byte
      if (byte_evt) begin
        case (cur_cmd)
          op_signature: tx_data <= sig_value;
          op_status:    tx_data <= 8'(dma_busy) << status_busy_bit;
          op_read:      tx_data <= tx_data;
          default:      tx_data <= 8'h00;
        endcase
      end
      if (rdata_valid)
        tx_data <= rdata;
    end
  end

  // request payload, dma start parameters
  always_ff @(posedge clk) begin
    if (wr_evt || rd_evt) begin
      req_we    <= wr_evt;
      req_addr  <= addr;
      req_wdata <= rx_data;
    end
    if (dma_evt) begin
      dma_addr  <= addr;
      dma_count <= rx_data;
    end
  end

  // request and its address hold until the arbiter takes it
  assert property (@(posedge clk) disable iff (reset)
    req_valid && !req_ready |=> req_valid && $stable(req_addr))
    else $error("mcu_cmd: request dropped before grant");

endmodule

//--- spi_byte_port.sv
`timescale 1ns/100ps

module spi_byte_port (
  input  logic       clk,
  input  logic       reset,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  input  logic [7:0] tx_data,
  output logic       cmd_ready,
  output logic       param_ready,
  output logic [7:0] rx_data,
  output logic [7:0] byte_cnt,
  output logic       frame_end
);

  // two sync stages, third stage only for edge detect
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] mosi_q;
  logic [2:0] bit_cnt;
  logic [7:0] byte_idx;
  logic [6:0] rx_shift;
  logic [7:0] tx_shift;
  logic       active;
  logic       sck_rise;
  logic       sck_fall;

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_q  <= '0;
      cs_q   <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign active   = ~cs_q[1];
  assign sck_rise = active & sck_q[1] & ~sck_q[2];
  assign sck_fall = active & ~sck_q[1] & sck_q[2];

  ////////////////////////////////////////////////////////////
  // bit and byte counting, miso shifter

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt     <= '0;
      byte_idx    <= '0;
      tx_shift    <= '0;
      miso        <= 1'b0;
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      frame_end   <= 1'b0;
    end else begin
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      // cs_n rising edge closes the frame
      frame_end   <= cs_q[1] & ~cs_q[2];
      if (!active) begin
        bit_cnt  <= '0;
        byte_idx <= '0;
        tx_shift <= '0;
        miso     <= 1'b0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            byte_idx    <= byte_idx + 8'd1;
            cmd_ready   <= (byte_idx == 8'd0);
            param_ready <= (byte_idx != 8'd0);
          end
        end
        if (sck_fall) begin
          // falling edge after the last bit starts the next reply byte
          if (bit_cnt == 3'd0) begin
            tx_shift <= tx_data;
            miso     <= tx_data[7];
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
            miso     <= tx_shift[6];
          end
        end
      end
    end
  end

  // receive data path
  always_ff @(posedge clk) begin
    if (sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_q[1]};
      if (bit_cnt == 3'd7) begin
        rx_data  <= {rx_shift, mosi_q[1]};
        byte_cnt <= byte_idx;
      end
    end
  end

  // a completed byte is either the command or a parameter
  assert property (@(posedge clk) disable iff (reset) !(cmd_ready && param_ready))
    else $error("spi_byte_port: cmd_ready and param_ready together");

endmodule

//--- cart_cmd_pkg.sv
package cart_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // byte store geometry

  // 1024 bytes, addressed with 10 bits
  localparam int store_addr_w = 10;
  localparam int store_depth  = 1 << store_addr_w;

  // rom mask register as seen by the console side
  localparam int rom_mask_w = 24;

  ////////////////////////////////////////////////////////////
  // command opcodes, first byte of a frame

  // two parameter bytes, high then low
  localparam logic [7:0] op_set_addr  = 8'h00;
  // three parameter bytes, high first
  localparam logic [7:0] op_rom_mask  = 8'h10;
  // high nibble only, low nibble carries the mapper
  localparam logic [3:0] op_mapper    = 4'h3;
  // one parameter byte, the count
  localparam logic [7:0] op_dma_start = 8'h40;
  // bursts with address auto-increment
  localparam logic [7:0] op_read      = 8'h80;
  localparam logic [7:0] op_write     = 8'h90;
  // queries
  localparam logic [7:0] op_signature = 8'hF0;
  localparam logic [7:0] op_status    = 8'hF1;

  ////////////////////////////////////////////////////////////
  // reply constants

  localparam logic [7:0] sig_value = 8'hA5;

  // position of the dma busy flag in the status reply
  localparam int status_busy_bit = 7;

endpackage
